// File: conv2d_top.f
+incdir+logic
logic/conv_pkg.sv
logic/conv_window_buffer.sv
logic/conv_channel_mac.sv
logic/conv_output_stage.sv
logic/conv2d_top.sv
verification/conv2d_chk.sv
verification/conv2d_tb.sv

// File: Makefile
# Verilator flow for the conv2d layer and its testbench
# Any variable can be overridden, for example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= conv2d_tb
RTL_TOP   ?= conv2d_top
FILELIST  ?= conv2d_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test passed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
# Keep running past assertion errors so the testbench can count them
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/conv2d_tb.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv2d_tb;
    import conv_pkg::*;

    localparam int W = `CONV_IMG_WIDTH;
    localparam int K = `CONV_KERNEL;
    localparam int OUT_W = `CONV_OUT_WIDTH;
    localparam int S = `CONV_STRIDE;
    localparam int CH = `CONV_OUT_CHANNELS;
    localparam int PIXELS = W * W;
    localparam int KEPT = (OUT_W / S) * (OUT_W / S);
    localparam int CLK_PERIOD = 100;
    localparam int NUM_IMAGES = 10;
    // MAC sweep plus handshake slack, doubled for random stalls
    localparam int CYCLES_PER_PIXEL = (CH + 2) * 2;
    localparam int TIMEOUT_CYCLES = NUM_IMAGES * PIXELS * CYCLES_PER_PIXEL * 8;
    localparam int DRAIN_CYCLES = 4 * (CH + 3);

    logic          clk;
    logic          reset;
    pixel_beat_t   pixel_in;
    logic          pixel_valid;
    logic          pixel_ready;
    kernel_bank_t  weights;
    bias_vec_t     bias;
    feature_beat_t feat_out;
    logic          feat_valid;
    logic          feat_ready;

    // Current image and expected output beats
    value_t        img [PIXELS];
    feature_beat_t exp_q [$];
    feature_beat_t exp_beat;

    int   err_count = 0;
    int   check_count = 0;
    int   tests_run = 0;
    int   beat_count = 0;
    int   last_count = 0;
    int   pix_count = 0;
    int   pix_at_first = 0;
    int   gap_pct = 0;
    int   stall_pct = 0;
    logic seen_valid = 1'b0;
    logic expect_zero = 1'b0;

    conv2d_top uut (
        .clk       (clk),
        .reset     (reset),
        .i_pixel   (pixel_in),
        .i_valid   (pixel_valid),
        .o_ready   (pixel_ready),
        .i_weights (weights),
        .i_bias    (bias),
        .o_feature (feat_out),
        .o_valid   (feat_valid),
        .i_ready   (feat_ready)
    );

    bind conv2d_top conv2d_chk u_chk (
        .clk       (clk),
        .reset     (reset),
        .o_feature (o_feature),
        .o_valid   (o_valid),
        .i_ready   (i_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_feature(input string name, input feature_t got, input feature_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_last(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Downstream ready, random stalls when stall_pct is set
    always @(posedge clk) begin
        feat_ready <= ($urandom_range(99) >= stall_pct);
    end

    // Pixels accepted so far
    always @(posedge clk) begin
        if (!reset && pixel_valid && pixel_ready) begin
            pix_count <= pix_count + 1;
        end
    end

    // Output monitor, one expected beat popped per transfer
    always @(posedge clk) begin
        if (!reset && feat_valid && !seen_valid) begin
            seen_valid = 1'b1;
            pix_at_first = pix_count;
        end
        if (!reset && feat_valid && feat_ready) begin
            beat_count++;
            if (feat_out.last) begin
                last_count++;
            end
            if (expect_zero) begin
                compare_feature("o_feature.data", feat_out.data, '0);
            end
            if (exp_q.size() == 0) begin
                err_count++;
                $display("ERROR at %0t: output beat arrived with nothing expected", $time);
            end else begin
                exp_beat = exp_q.pop_front();
                compare_feature("o_feature.data", feat_out.data, exp_beat.data);
                compare_last("o_feature.last", feat_out.last, exp_beat.last);
            end
        end
    end

    // Mode 0 full range, 1 small data with negative bias, 2 small data with positive bias
    task automatic load_params(input int mode);
        kernel_bank_t w_next;
        bias_vec_t    b_next;
        for (int ch = 0; ch < CH; ch++) begin
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K; c++) begin
                    w_next[ch][r][c] = (mode == 0) ? value_t'($urandom)
                                                   : value_t'($urandom_range(255));
                end
            end
            if (mode == 0) begin
                b_next[ch] = value_t'($urandom);
            end else if (mode == 1) begin
                b_next[ch] = value_t'(-20000);
            end else begin
                b_next[ch] = value_t'($urandom_range(1000));
            end
        end
        @(posedge clk);
        weights <= w_next;
        bias    <= b_next;
        // Let the new levels settle before the model reads them
        @(posedge clk);
    endtask

    // Reference convolution over the whole image
    task automatic build_expected();
        feature_beat_t beat;
        product_t      prod;
        value_t        acc;
        for (int r = 0; r < OUT_W; r++) begin
            for (int c = 0; c < OUT_W; c++) begin
                // Only stride positions reach the output
                if ((r % S == S - 1) && (c % S == S - 1)) begin
                    for (int ch = 0; ch < CH; ch++) begin
                        acc = '0;
                        for (int kr = 0; kr < K; kr++) begin
                            for (int kc = 0; kc < K; kc++) begin
                                prod = $signed(img[(r + kr) * W + c + kc])
                                     * $signed(weights[ch][kr][kc]);
                                acc = acc + prod[`CONV_FRAC_BITS +: `CONV_VALUE_BITS];
                            end
                        end
                        acc = acc + bias[ch];
                        // ReLU
                        beat.data[ch] = (acc < 0) ? '0 : acc;
                    end
                    beat.last = (r == OUT_W - 1) && (c == OUT_W - 1);
                    exp_q.push_back(beat);
                end
            end
        end
    endtask

    // Stream one image, gaps only when no beat is waiting
    task automatic drive_image();
        int idx;
        idx = 0;
        while (idx < PIXELS) begin
            @(posedge clk);
            if (pixel_valid && pixel_ready) begin
                idx++;
            end
            if (!pixel_valid || pixel_ready) begin
                if (idx < PIXELS && $urandom_range(99) >= gap_pct) begin
                    pixel_valid <= 1'b1;
                    pixel_in    <= '{data: img[idx], last: (idx == PIXELS - 1)};
                end else begin
                    pixel_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic run_image(input int mode);
        for (int i = 0; i < PIXELS; i++) begin
            img[i] = (mode == 0) ? value_t'($urandom) : value_t'($urandom_range(255));
        end
        build_expected();
        drive_image();
    endtask

    // All expected beats seen, then idle a while to catch extra ones
    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        // Line buffer back to empty and taking pixels again
        compare_last("o_ready", pixel_ready, 1'b1);
    endtask

    task automatic check_totals(input int beats_before, input int lasts_before, input int images);
        if (beat_count - beats_before != images * KEPT) begin
            err_count++;
            $display("MISMATCH at %0t: o_valid beat count got %0d expected %0d",
                     $time, beat_count - beats_before, images * KEPT);
        end
        if (last_count - lasts_before != images) begin
            err_count++;
            $display("MISMATCH at %0t: o_feature.last count got %0d expected %0d",
                     $time, last_count - lasts_before, images);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        int beats;
        int lasts;
        void'($urandom(4889));
        clk         = 1'b0;
        reset       = 1'b1;
        pixel_in    = '0;
        pixel_valid = 1'b0;
        weights     = '0;
        bias        = '0;
        feat_ready  = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Quiet output and ready input after reset, first output once row three has begun
        errs = err_count;
        repeat (20) begin
            @(posedge clk);
            compare_last("o_valid", feat_valid, 1'b0);
            compare_last("o_ready", pixel_ready, 1'b1);
        end
        load_params(0);
        run_image(0);
        wait_drain();
        if (!seen_valid) begin
            err_count++;
            $display("ERROR: no output appeared for the first image");
        end else if (pix_at_first <= 2 * W) begin
            err_count++;
            $display("ERROR: first output came after only %0d input pixels", pix_at_first);
        end
        report_test("reset and first output", errs);

        // Single random image
        errs  = err_count;
        beats = beat_count;
        lasts = last_count;
        load_params(0);
        run_image(0);
        wait_drain();
        check_totals(beats, lasts, 1);
        report_test("random image", errs);

        // Clipping to zero, then a bias that never clips
        errs  = err_count;
        beats = beat_count;
        lasts = last_count;
        expect_zero = 1'b1;
        load_params(1);
        run_image(1);
        wait_drain();
        expect_zero = 1'b0;
        load_params(2);
        run_image(1);
        wait_drain();
        check_totals(beats, lasts, 2);
        report_test("bias and relu", errs);

        // Stride mask, last only on the final kept window
        errs  = err_count;
        beats = beat_count;
        lasts = last_count;
        run_image(0);
        wait_drain();
        check_totals(beats, lasts, 1);
        report_test("stride mask", errs);

        // Input gaps and output stalls
        errs  = err_count;
        beats = beat_count;
        lasts = last_count;
        gap_pct   = 30;
        stall_pct = 40;
        load_params(0);
        run_image(0);
        run_image(0);
        wait_drain();
        gap_pct   = 0;
        stall_pct = 0;
        check_totals(beats, lasts, 2);
        report_test("gaps and back-pressure", errs);

        // Three images with no drain in between
        errs  = err_count;
        beats = beat_count;
        lasts = last_count;
        load_params(0);
        run_image(0);
        run_image(0);
        run_image(0);
        wait_drain();
        check_totals(beats, lasts, 3);
        report_test("back to back images", errs);

        // Handshake rules from the bound checker
        err_count = err_count + uut.u_chk.fail_count;
        $display("Tests run: %0d, checks: %0d, assertion failures: %0d, errors: %0d",
                 tests_run, check_count, uut.u_chk.fail_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("ERROR: run did not finish within %0d cycles, %0d output beats outstanding",
                 TIMEOUT_CYCLES, exp_q.size());
        $display("Test failed");
        $finish;
    end

endmodule

// File: verification/conv2d_chk.sv
`timescale 1ns/1ps

module conv2d_chk (
    input logic                    clk,
    input logic                    reset,
    input conv_pkg::feature_beat_t o_feature,
    input logic                    o_valid,
    input logic                    i_ready
);
    // Failed assertions, summed into the testbench error count
    int fail_count = 0;

    // Stalled beat keeps valid and payload until it transfers
    assert property (@(posedge clk) disable iff (reset)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_feature)))
    else begin
        fail_count++;
        $error("output payload changed while stalled");
    end

    // last only together with valid
    assert property (@(posedge clk) disable iff (reset) o_feature.last |-> o_valid)
    else begin
        fail_count++;
        $error("o_feature.last high without o_valid");
    end

    // Nothing leaves while reset is held
    assert property (@(posedge clk) (reset && $past(reset)) |-> !o_valid)
    else begin
        fail_count++;
        $error("o_valid high during reset");
    end

endmodule

// File: logic/conv2d_top.sv
`timescale 1ns/1ps

module conv2d_top (
    input  logic                    clk,
    input  logic                    reset,
    // Pixel stream in
    input  conv_pkg::pixel_beat_t   i_pixel,
    input  logic                    i_valid,
    output logic                    o_ready,
    // Layer parameters
    input  conv_pkg::kernel_bank_t  i_weights,
    input  conv_pkg::bias_vec_t     i_bias,
    // Feature stream out
    output conv_pkg::feature_beat_t o_feature,
    output logic                    o_valid,
    input  logic                    i_ready
);
    import conv_pkg::*;

    // Line buffer to MAC
    window_beat_t  win_beat;
    logic          win_valid;
    logic          win_ready;

    // MAC to output stage
    feature_beat_t mac_beat;
    logic          mac_valid;
    logic          mac_ready;

    conv_window_buffer u_window_buffer (
        .clk      (clk),
        .reset    (reset),
        .i_pixel  (i_pixel),
        .i_valid  (i_valid),
        .o_ready  (o_ready),
        .o_window (win_beat),
        .o_valid  (win_valid),
        .i_ready  (win_ready)
    );

    conv_channel_mac u_channel_mac (
        .clk       (clk),
        .reset     (reset),
        .i_window  (win_beat),
        .i_valid   (win_valid),
        .o_ready   (win_ready),
        .i_weights (i_weights),
        .o_feature (mac_beat),
        .o_valid   (mac_valid),
        .i_ready   (mac_ready)
    );

    conv_output_stage u_output_stage (
        .clk       (clk),
        .reset     (reset),
        .i_feature (mac_beat),
        .i_valid   (mac_valid),
        .o_ready   (mac_ready),
        .i_bias    (i_bias),
        .o_feature (o_feature),
        .o_valid   (o_valid),
        .i_ready   (i_ready)
    );

endmodule

// File: logic/conv_output_stage.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_output_stage (
    input  logic                    clk,
    input  logic                    reset,
    // Raw dot products in
    input  conv_pkg::feature_beat_t i_feature,
    input  logic                    i_valid,
    output logic                    o_ready,
    // Per channel bias
    input  conv_pkg::bias_vec_t     i_bias,
    // Activated features out
    output conv_pkg::feature_beat_t o_feature,
    output logic                    o_valid,
    input  logic                    i_ready
);
    import conv_pkg::*;

    localparam int CH = `CONV_OUT_CHANNELS;
    localparam int S = `CONV_STRIDE;
    localparam int COL_BITS = (`CONV_OUT_WIDTH > 1) ? $clog2(`CONV_OUT_WIDTH) : 1;
    localparam int MOD_BITS = (S > 1) ? $clog2(S) : 1;
    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(`CONV_OUT_WIDTH - 1);
    localparam logic [MOD_BITS-1:0] LAST_MOD = MOD_BITS'(S - 1);

    feature_t            biased;
    feature_t            data_q;
    logic                valid_q;
    logic                last_q;

    // Position of the window held in the register
    logic [COL_BITS-1:0] col_cnt;
    logic [MOD_BITS-1:0] col_mod;
    logic [MOD_BITS-1:0] row_mod;

    logic                keep;
    logic                leave;
    logic                accept;

    // Stride mask
    assign keep   = (row_mod == LAST_MOD) && (col_mod == LAST_MOD);
    // Skipped windows drain without waiting for downstream
    assign leave  = valid_q && (i_ready || !keep);
    assign o_ready = !valid_q || leave;
    assign accept = i_valid && o_ready;

    // Bias add then ReLU, both wrap in the value width
    always_comb begin
        value_t sum;
        for (int ch = 0; ch < CH; ch++) begin
            sum = i_feature.data[ch] + i_bias[ch];
            biased[ch] = sum[`CONV_VALUE_BITS-1] ? '0 : sum;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data_q <= biased;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
            last_q  <= i_feature.last;
        end else if (leave) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
    end

    // Advance the window position as each beat leaves, restart per image
    always_ff @(posedge clk) begin
        if (reset || (leave && last_q)) begin
            col_cnt <= '0;
            col_mod <= '0;
            row_mod <= '0;
        end else if (leave) begin
            if (col_cnt == LAST_COL) begin
                col_cnt <= '0;
                col_mod <= '0;
                row_mod <= (row_mod == LAST_MOD) ? '0 : row_mod + 1'b1;
            end else begin
                col_cnt <= col_cnt + 1'b1;
                col_mod <= (col_mod == LAST_MOD) ? '0 : col_mod + 1'b1;
            end
        end
    end

    assign o_valid   = valid_q && keep;
    assign o_feature = '{data: data_q, last: last_q && keep};

endmodule

// File: logic/conv_channel_mac.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_channel_mac (
    input  logic                    clk,
    input  logic                    reset,
    // Window stream in
    input  conv_pkg::window_beat_t  i_window,
    input  logic                    i_valid,
    output logic                    o_ready,
    // Kernel weights, stable for the whole image
    input  conv_pkg::kernel_bank_t  i_weights,
    // Feature stream out
    output conv_pkg::feature_beat_t o_feature,
    output logic                    o_valid,
    input  logic                    i_ready
);
    import conv_pkg::*;

    localparam int K = `CONV_KERNEL;
    localparam int TAPS = K * K;
    localparam int CH = `CONV_OUT_CHANNELS;
    localparam int SLOT_BITS = (CH > 1) ? $clog2(CH) : 1;
    localparam chan_idx_t LAST_CHAN = chan_idx_t'(CH - 1);

    mac_state_t           state;

    // Captured window
    window_t              win_q;
    logic                 last_q;

    // Channel sweep, products lag the counter by one cycle
    chan_idx_t            chan;
    chan_idx_t            prod_chan;
    logic                 prod_valid;
    product_t             prod_q [TAPS];
    value_t               dot;
    feature_t             result_q;

    logic                 accept;
    logic                 issue;
    logic [SLOT_BITS-1:0] slot;
    logic [SLOT_BITS-1:0] prod_slot;

    assign o_ready   = (state == MAC_IDLE);
    assign accept    = i_valid && o_ready;
    // Start one channel per cycle until all are issued
    assign issue     = (state == MAC_RUN) && (chan <= LAST_CHAN);
    assign slot      = chan[SLOT_BITS-1:0];
    assign prod_slot = prod_chan[SLOT_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= MAC_IDLE;
            chan       <= '0;
            prod_valid <= 1'b0;
        end else begin
            case (state)
                MAC_IDLE: begin
                    if (i_valid) begin
                        state <= MAC_RUN;
                        chan  <= '0;
                    end
                end
                MAC_RUN: begin
                    prod_valid <= issue;
                    if (issue) begin
                        chan <= chan + 1'b1;
                    end
                    // Last slot gets written on this edge
                    if (prod_valid && (prod_chan == LAST_CHAN)) begin
                        state <= MAC_HOLD;
                    end
                end
                MAC_HOLD: begin
                    if (i_ready) begin
                        state <= MAC_IDLE;
                    end
                end
                default: state <= MAC_IDLE;
            endcase
        end
    end

    // Window capture, multiply stage and result slots
    always_ff @(posedge clk) begin
        if (accept) begin
            win_q  <= i_window.taps;
            last_q <= i_window.last;
        end
        if (issue) begin
            prod_chan <= chan;
            for (int r = 0; r < K; r++) begin
                for (int c = 0; c < K; c++) begin
                    prod_q[r*K + c] <= $signed(win_q[r*K + c]) * $signed(i_weights[slot][r][c]);
                end
            end
        end
        if (prod_valid) begin
            result_q[prod_slot] <= dot;
        end
    end

    // Sum the truncated products, wrapping in the value width
    always_comb begin
        dot = '0;
        for (int t = 0; t < TAPS; t++) begin
            dot = dot + value_t'(prod_q[t][`CONV_FRAC_BITS +: `CONV_VALUE_BITS]);
        end
    end

    assign o_valid   = (state == MAC_HOLD);
    // last only shows together with the finished result
    assign o_feature = '{data: result_q, last: last_q && (state == MAC_HOLD)};

endmodule

// File: logic/conv_window_buffer.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_window_buffer (
    input  logic                   clk,
    input  logic                   reset,
    // Pixel stream in
    input  conv_pkg::pixel_beat_t  i_pixel,
    input  logic                   i_valid,
    output logic                   o_ready,
    // Window stream out
    output conv_pkg::window_beat_t o_window,
    output logic                   o_valid,
    input  logic                   i_ready
);
    import conv_pkg::*;

    localparam int K = `CONV_KERNEL;
    // Bottom tap row comes from the live pixel, so one RAM fewer than rows
    localparam int LINES = K - 1;
    localparam int SEL_BITS = (LINES > 1) ? $clog2(LINES) : 1;
    localparam col_addr_t LAST_COL = col_addr_t'(`CONV_IMG_WIDTH - 1);
    localparam col_addr_t FIRST_WIN_COL = col_addr_t'(K - 1);
    localparam logic [SEL_BITS-1:0] LAST_SEL = SEL_BITS'(LINES - 1);

    // Line storage and its registered read port
    value_t              line_ram [LINES][`CONV_IMG_WIDTH];
    value_t              ram_rd_q [LINES];
    value_t              new_col  [K];

    // Window register, doubles as the output payload
    window_t             taps_q;
    logic                last_q;
    logic                valid_q;

    // Write side bookkeeping
    col_addr_t           wr_col;
    col_addr_t           rd_addr;
    logic [SEL_BITS-1:0] wr_sel;
    logic                rows_ready;

    logic                accept;
    logic                row_end;
    logic                win_ok;
    logic                drain;

    // Hold off input while a window is stuck or the final window waits
    assign o_ready = !last_q && (!valid_q || i_ready);
    assign accept  = i_valid && o_ready;
    assign row_end = (wr_col == LAST_COL);

    // Enough rows stored and enough columns shifted in
    assign win_ok  = rows_ready && (wr_col >= FIRST_WIN_COL);

    // Final window of the image leaves this cycle
    assign drain   = valid_q && last_q && i_ready;

    // Read one column ahead so the data is ready when the pixel arrives
    assign rd_addr = !accept ? wr_col : (row_end ? '0 : wr_col + 1'b1);

    // Line RAMs, read happens before the write at the same column
    always_ff @(posedge clk) begin
        for (int i = 0; i < LINES; i++) begin
            if (accept && (wr_sel == SEL_BITS'(i))) begin
                line_ram[i][wr_col] <= i_pixel.data;
            end
            ram_rd_q[i] <= line_ram[i][rd_addr];
        end
    end

    // Map RAMs onto tap rows
    // The RAM under write holds the oldest row, so it feeds the top row
    always_comb begin
        int src;
        for (int row = 0; row < LINES; row++) begin
            src = int'(wr_sel) + row;
            if (src >= LINES) begin
                src = src - LINES;
            end
            new_col[row] = ram_rd_q[src];
        end
        // Bottom row is the pixel on the input right now
        new_col[K-1] = i_pixel.data;
    end

    // Slide the window one column to the right per accepted pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int row = 0; row < K; row++) begin
                for (int col = 0; col < K - 1; col++) begin
                    taps_q[row*K + col] <= taps_q[row*K + col + 1];
                end
                taps_q[row*K + K - 1] <= new_col[row];
            end
        end
    end

    // Pointers, startup flag and output valid
    always_ff @(posedge clk) begin
        if (reset || drain) begin
            wr_col     <= '0;
            wr_sel     <= '0;
            rows_ready <= 1'b0;
            valid_q    <= 1'b0;
            last_q     <= 1'b0;
        end else if (accept) begin
            // A new window replaces any one leaving on this edge
            valid_q <= win_ok;
            last_q  <= i_pixel.last;
            if (row_end) begin
                wr_col <= '0;
                // Rotate the scratch RAM
                wr_sel <= (wr_sel == LAST_SEL) ? '0 : wr_sel + 1'b1;
                // K-1 rows stored after the first full rotation
                if (wr_sel == LAST_SEL) begin
                    rows_ready <= 1'b1;
                end
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end else if (valid_q && i_ready) begin
            valid_q <= 1'b0;
        end
    end

    assign o_valid  = valid_q;
    assign o_window = '{taps: taps_q, last: last_q};

endmodule

// File: logic/conv_pkg.sv
`include "conv_macros.svh"

package conv_pkg;

    // Basic fixed point quantities
    typedef logic signed [`CONV_VALUE_BITS-1:0] value_t;
    typedef logic signed [2*`CONV_VALUE_BITS-1:0] product_t;

    // Column pointer into a line RAM
    typedef logic [$clog2(`CONV_IMG_WIDTH)-1:0] col_addr_t;

    // Channel counter, one extra code marks the end of a sweep
    typedef logic [$clog2(`CONV_OUT_CHANNELS+1)-1:0] chan_idx_t;

    // Window taps, index row*K+col, index 0 is the top-left tap
    typedef value_t [`CONV_KERNEL*`CONV_KERNEL-1:0] window_t;
    typedef value_t [`CONV_OUT_CHANNELS-1:0] feature_t;
    typedef value_t [`CONV_OUT_CHANNELS-1:0][`CONV_KERNEL-1:0][`CONV_KERNEL-1:0] kernel_bank_t;
    typedef value_t [`CONV_OUT_CHANNELS-1:0] bias_vec_t;

    // Stream payloads
    typedef struct packed {
        value_t data;
        logic   last;
    } pixel_beat_t;

    typedef struct packed {
        window_t taps;
        logic    last;
    } window_beat_t;

    typedef struct packed {
        feature_t data;
        logic     last;
    } feature_beat_t;

    typedef enum logic [1:0] {MAC_IDLE, MAC_RUN, MAC_HOLD} mac_state_t;

endpackage

// File: logic/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Pixels per image row
`define CONV_IMG_WIDTH 8

// Kernel side length, windows are square
`define CONV_KERNEL 3

// Windows produced along one row
`define CONV_OUT_WIDTH ((`CONV_IMG_WIDTH) - (`CONV_KERNEL) + 1)

// Signed fixed point value, shared by pixels, weights, bias and results
`define CONV_VALUE_BITS 16

// Fractional bits of the value format
`define CONV_FRAC_BITS 8

// Output channels computed per window
`define CONV_OUT_CHANNELS 4

// Step between kept windows in both directions
`define CONV_STRIDE 2

`endif
